// ==== src/bpred_defines.svh ====
`ifndef BPRED_DEFINES_SVH
`define BPRED_DEFINES_SVH

// Instruction address width
`define BPRED_XLEN 32

// Counter table index width
// 4 bits gives a table of 16 counters
`define BPRED_BHT_IDX_BITS 4

// Return address stack entries
// The oldest entry falls off when a push hits a full stack
`define BPRED_RAS_DEPTH 4

`endif

// ==== src/bpred_pkg.sv ====
`include "bpred_defines.svh"

package bpred_pkg;

  // Instruction address
  typedef logic [`BPRED_XLEN-1:0] addr_t;

  // Counter table index, taken from pc[2 +: idx bits]
  typedef logic [`BPRED_BHT_IDX_BITS-1:0] bht_idx_t;

  // 2-bit saturating counter, upper bit means predict taken
  typedef logic [1:0] ctr_t;

  // Which rule flagged the mispredict
  typedef enum logic [1:0] {
    MP_NONE,
    MP_BRANCH,
    MP_JALR
  } mispred_kind_e;

  // Decoded instruction with its resolved outcome
  typedef struct packed {
    addr_t pc;
    logic  is_branch;
    // JAL or JALR that writes the link register
    logic  is_call;
    // JALR used as a return
    logic  is_ret;
    logic  actual_taken;
    addr_t actual_target;
  } inst_rec_t;

  // Instruction plus what the lookup stage guessed
  typedef struct packed {
    inst_rec_t inst;
    logic      pred_taken;
    addr_t     pred_target;
  } pred_rec_t;

  // Feedback from MEM to the lookup stage
  typedef struct packed {
    logic     valid;
    bht_idx_t idx;
    logic     taken;
    logic     push;
    logic     pop;
    addr_t    push_addr;
  } train_t;

  // Front-end redirect request
  typedef struct packed {
    logic          valid;
    addr_t         pc;
    mispred_kind_e kind;
  } redirect_t;

  // Table index for a given pc
  function automatic bht_idx_t pc_to_idx(addr_t pc);
    return pc[2+:`BPRED_BHT_IDX_BITS];
  endfunction

endpackage

// ==== src/bpred_lookup.sv ====
`include "bpred_defines.svh"

module bpred_lookup
  import bpred_pkg::*;
#(
  parameter bit ras_enable = 1'b1
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      in_valid,
  input  inst_rec_t in_rec,
  input  train_t    train,
  output logic      ex_valid,
  output pred_rec_t ex_rec
);

  localparam int bht_entries = 1 << `BPRED_BHT_IDX_BITS;
  localparam int ras_depth = `BPRED_RAS_DEPTH;

  // Counter table
  ctr_t  bht[bht_entries];
  ctr_t  lookup_ctr;
  ctr_t  train_ctr;
  ctr_t  train_ctr_next;

  // RAS view seen by the predictor
  logic  ras_empty;
  addr_t ras_top;

  assign lookup_ctr = bht[pc_to_idx(in_rec.pc)];
  assign train_ctr  = bht[train.idx];

  // Saturating update of the trained counter
  always_comb begin
    train_ctr_next = train_ctr;
    if (train.taken && train_ctr != 2'b11) begin
      train_ctr_next = train_ctr + 2'd1;
    end else if (!train.taken && train_ctr != 2'b00) begin
      train_ctr_next = train_ctr - 2'd1;
    end
  end

  // All counters start weakly not-taken
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < bht_entries; i++) begin
        bht[i] <= 2'b01;
      end
    end else if (train.valid) begin
      bht[train.idx] <= train_ctr_next;
    end
  end

  if (ras_enable) begin : g_ras
    typedef logic [$clog2(ras_depth+1)-1:0] ras_cnt_t;

    addr_t    ras_stack[ras_depth];
    ras_cnt_t ras_count;

    // Occupancy, saturating at full since old entries are dropped
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        ras_count <= '0;
      end else if (train.push && !train.pop) begin
        if (ras_count != ras_cnt_t'(ras_depth)) begin
          ras_count <= ras_count + 1'b1;
        end
      end else if (train.pop && !train.push) begin
        if (ras_count != '0) begin
          ras_count <= ras_count - 1'b1;
        end
      end else if (train.push && train.pop && ras_count == '0) begin
        ras_count <= ras_cnt_t'(1);
      end
    end

    // Entry 0 is the top, a push shifts everything one slot deeper
    always_ff @(posedge clk) begin
      if (train.push && train.pop) begin
        // Pop then push collapses to replacing the top
        ras_stack[0] <= train.push_addr;
      end else if (train.push) begin
        for (int i = ras_depth - 1; i > 0; i--) begin
          ras_stack[i] <= ras_stack[i-1];
        end
        ras_stack[0] <= train.push_addr;
      end else if (train.pop) begin
        for (int i = 0; i < ras_depth - 1; i++) begin
          ras_stack[i] <= ras_stack[i+1];
        end
      end
    end

    assign ras_empty = (ras_count == '0);
    assign ras_top   = ras_stack[0];
  end else begin : g_no_ras
    // Returns are never predicted
    assign ras_empty = 1'b1;
    assign ras_top   = '0;
  end

  // Attach the prediction
  always_comb begin
    ex_rec.inst        = in_rec;
    ex_rec.pred_taken  = 1'b0;
    ex_rec.pred_target = in_rec.pc + addr_t'(4);
    if (in_rec.is_branch) begin
      // Direction only, target stands in for a BTB hit
      ex_rec.pred_taken  = lookup_ctr[1];
      ex_rec.pred_target = in_rec.actual_target;
    end else if (in_rec.is_ret && !ras_empty) begin
      ex_rec.pred_taken  = 1'b1;
      ex_rec.pred_target = ras_top;
    end
  end

  assign ex_valid = in_valid;

endmodule

// ==== src/bpred_ex_mem_reg.sv ====
module bpred_ex_mem_reg
  import bpred_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      ex_valid,
  input  pred_rec_t ex_rec,
  input  logic      flush,
  output logic      mem_valid,
  output pred_rec_t mem_rec
);

  // Register between EX and MEM
  // Mispredict compare runs off these flops, not the EX logic cone

  logic capture;

  // A flushed record is dropped on the way in
  assign capture = ex_valid && !flush;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_valid <= 1'b0;
    end else begin
      mem_valid <= capture;
    end
  end

  // Payload holds its old value when nothing is captured
  always_ff @(posedge clk) begin
    if (capture) begin
      mem_rec <= ex_rec;
    end
  end

endmodule

// ==== src/bpred_mem_check.sv ====
module bpred_mem_check
  import bpred_pkg::*;
#(
  parameter bit ras_enable = 1'b1
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      mem_valid,
  input  pred_rec_t mem_rec,
  output logic      flush,
  output train_t    train,
  output redirect_t redirect,
  output logic      retire_valid,
  output addr_t     retire_pc
);

  logic          branch_mispred;
  logic          jalr_mispred;
  addr_t         pc_plus4;
  addr_t         redirect_pc_d;
  mispred_kind_e kind_d;

  assign pc_plus4 = mem_rec.inst.pc + addr_t'(4);

  // Branch direction check
  assign branch_mispred = mem_valid && mem_rec.inst.is_branch &&
      (mem_rec.inst.actual_taken != mem_rec.pred_taken);

  if (ras_enable) begin : g_jalr_ras
    // Wrong if nothing was predicted or the stack held another address
    assign jalr_mispred = mem_valid && mem_rec.inst.is_ret &&
        (!mem_rec.pred_taken || (mem_rec.pred_target != mem_rec.inst.actual_target));
  end else begin : g_jalr_no_ras
    // No stack, so every return redirects
    assign jalr_mispred = mem_valid && mem_rec.inst.is_ret;
  end

  // Kill the instruction behind the one being checked
  assign flush = branch_mispred || jalr_mispred;

  // Where the front end must restart, and why
  always_comb begin
    kind_d        = MP_NONE;
    redirect_pc_d = mem_rec.inst.actual_target;
    if (branch_mispred) begin
      kind_d = MP_BRANCH;
      // Not-taken resolves to the fall-through
      if (!mem_rec.inst.actual_taken) begin
        redirect_pc_d = pc_plus4;
      end
    end else if (jalr_mispred) begin
      kind_d = MP_JALR;
    end
  end

  // Training back to the lookup stage, same cycle
  always_comb begin
    train.valid     = mem_valid && mem_rec.inst.is_branch;
    train.idx       = pc_to_idx(mem_rec.inst.pc);
    train.taken     = mem_rec.inst.actual_taken;
    train.push      = mem_valid && mem_rec.inst.is_call;
    train.pop       = mem_valid && mem_rec.inst.is_ret;
    // Link address of the call
    train.push_addr = pc_plus4;
  end

  // Registered outputs, one cycle after the check
  always_ff @(posedge clk) begin
    redirect.pc <= redirect_pc_d;
    retire_pc   <= mem_rec.inst.pc;
    if (!rst_n) begin
      redirect.valid <= 1'b0;
      redirect.kind  <= MP_NONE;
      retire_valid   <= 1'b0;
    end else begin
      redirect.valid <= flush;
      redirect.kind  <= kind_d;
      // A mispredicting instruction still retires
      retire_valid   <= mem_valid;
    end
  end

endmodule

// ==== src/bpred_top.sv ====
module bpred_top
  import bpred_pkg::*;
#(
  parameter bit ras_enable = 1'b1
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      in_valid,
  input  inst_rec_t in_rec,
  output redirect_t redirect,
  output logic      retire_valid,
  output addr_t     retire_pc
);

  // EX side, straight out of the lookup
  logic      ex_valid;
  pred_rec_t ex_rec;

  // MEM side, after the pipeline register
  logic      mem_valid;
  pred_rec_t mem_rec;

  // Feedback from the check stage
  train_t    train;
  logic      flush;

  bpred_lookup #(
    .ras_enable(ras_enable)
  ) u_lookup (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_valid(in_valid),
    .in_rec  (in_rec),
    .train   (train),
    .ex_valid(ex_valid),
    .ex_rec  (ex_rec)
  );

  bpred_ex_mem_reg u_ex_mem_reg (
    .clk      (clk),
    .rst_n    (rst_n),
    .ex_valid (ex_valid),
    .ex_rec   (ex_rec),
    .flush    (flush),
    .mem_valid(mem_valid),
    .mem_rec  (mem_rec)
  );

  bpred_mem_check #(
    .ras_enable(ras_enable)
  ) u_mem_check (
    .clk         (clk),
    .rst_n       (rst_n),
    .mem_valid   (mem_valid),
    .mem_rec     (mem_rec),
    .flush       (flush),
    .train       (train),
    .redirect    (redirect),
    .retire_valid(retire_valid),
    .retire_pc   (retire_pc)
  );

endmodule

// ==== testbench/bpred_checker.sv ====
module bpred_checker
  import bpred_pkg::*;
(
  input logic      clk,
  input logic      rst_n,
  input redirect_t redirect,
  input logic      retire_valid
);
  timeunit 1ns;
  timeprecision 100ps;

  // Failed property count
  int fail_count = 0;

  // A redirect always rides on the retiring instruction that caused it
  redirect_with_retire: assert property (
    @(posedge clk) disable iff (!rst_n) redirect.valid |-> retire_valid
  ) else begin
    fail_count++;
    $error("redirect raised without a retiring instruction");
  end

  // First cycle out of reset shows nothing valid
  quiet_after_reset: assert property (
    @(posedge clk) $rose(rst_n) |=> !redirect.valid && !retire_valid
  ) else begin
    fail_count++;
    $error("output valid in the first cycle after reset");
  end

  // Kind is MP_NONE exactly when there is no redirect
  kind_matches_valid: assert property (
    @(posedge clk) disable iff (!rst_n) (redirect.kind == MP_NONE) == !redirect.valid
  ) else begin
    fail_count++;
    $error("redirect kind disagrees with redirect valid");
  end

endmodule

bind bpred_top bpred_checker u_checker (
  .clk         (clk),
  .rst_n       (rst_n),
  .redirect    (redirect),
  .retire_valid(retire_valid)
);

// ==== testbench/bpred_tb.sv ====
`include "bpred_defines.svh"

module bpred_tb
  import bpred_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  // 1 + 6 + 4 + 3 + 40 instructions over all tests
  localparam int num_insts = 54;
  localparam int clk_period = 8;
  localparam int watchdog_cycles = num_insts * 4 + 200;

  logic      clk;
  logic      rst_n;
  logic      in_valid;
  inst_rec_t in_rec;
  redirect_t redirect;
  logic      retire_valid;
  addr_t     retire_pc;

  // Reference model state
  ctr_t        bht_m[1 << `BPRED_BHT_IDX_BITS];
  addr_t       ras_m[$];
  logic [31:0] lfsr_state;

  bpred_top #(
    .ras_enable(1'b1)
  ) UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_rec      (in_rec),
    .redirect    (redirect),
    .retire_valid(retire_valid),
    .retire_pc   (retire_pc)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // Word aligned address
  function automatic addr_t rand_pc();
    return rand_bits(30) << 2;
  endfunction

  function automatic inst_rec_t make_rec(logic br, logic call, logic ret, addr_t pc,
                                         logic taken, addr_t target);
    inst_rec_t r;
    r.pc            = pc;
    r.is_branch     = br;
    r.is_call       = call;
    r.is_ret        = ret;
    r.actual_taken  = taken;
    r.actual_target = target;
    return r;
  endfunction

  // Expected redirect for one instruction against the current model
  function automatic redirect_t model_redirect(inst_rec_t r);
    redirect_t e;
    bht_idx_t  idx;
    e.valid = 1'b0;
    e.pc    = '0;
    e.kind  = MP_NONE;
    idx     = r.pc[2 +: `BPRED_BHT_IDX_BITS];
    if (r.is_branch) begin
      if (r.actual_taken != bht_m[idx][1]) begin
        e.valid = 1'b1;
        e.kind  = MP_BRANCH;
        e.pc    = r.actual_taken ? r.actual_target : r.pc + 32'd4;
      end
    end else if (r.is_ret) begin
      // Empty stack or wrong top both go back to the real target
      if (ras_m.size() == 0 || ras_m[0] != r.actual_target) begin
        e.valid = 1'b1;
        e.kind  = MP_JALR;
        e.pc    = r.actual_target;
      end
    end
    return e;
  endfunction

  // Retire side effects: counter training and RAS commit
  task automatic model_update(input inst_rec_t r);
    bht_idx_t idx;
    idx = r.pc[2 +: `BPRED_BHT_IDX_BITS];
    if (r.is_branch) begin
      if (r.actual_taken && bht_m[idx] != 2'b11) begin
        bht_m[idx] = bht_m[idx] + 2'd1;
      end else if (!r.actual_taken && bht_m[idx] != 2'b00) begin
        bht_m[idx] = bht_m[idx] - 2'd1;
      end
    end
    if (r.is_call) begin
      // Full stack loses its oldest entry
      if (ras_m.size() == `BPRED_RAS_DEPTH) begin
        void'(ras_m.pop_back());
      end
      ras_m.push_front(r.pc + 32'd4);
    end
    if (r.is_ret && ras_m.size() != 0) begin
      void'(ras_m.pop_front());
    end
  endtask

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
      $display(">>> FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_outputs(input redirect_t exp, input addr_t pc);
    check_eq(32'(redirect.valid), 32'(exp.valid), "redirect.valid");
    check_eq(32'(redirect.kind), 32'(exp.kind), "redirect.kind");
    if (exp.valid) begin
      check_eq(redirect.pc, exp.pc, "redirect.pc");
    end
    check_eq(32'(retire_valid), 32'd1, "retire_valid");
    check_eq(retire_pc, pc, "retire_pc");
  endtask

  // One instruction in, fixed 2 cycle latency to the outputs
  task automatic send_and_check(input inst_rec_t r);
    redirect_t exp;
    exp = model_redirect(r);
    @(posedge clk);
    in_valid <= 1'b1;
    in_rec   <= r;
    @(posedge clk);
    in_valid <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_outputs(exp, r.pc);
    model_update(r);
  endtask

  task automatic reset_state_idle();
    repeat (3) begin
      @(negedge clk);
      check_eq(32'(redirect.valid), 32'd0, "redirect.valid after reset");
      check_eq(32'(retire_valid), 32'd0, "retire_valid after reset");
    end
  endtask

  task automatic empty_ras_return();
    send_and_check(make_rec(1'b0, 1'b0, 1'b1, rand_pc(), 1'b1, rand_pc()));
    check_eq(32'(redirect.valid), 32'd1, "empty RAS return redirect");
    check_eq(32'(redirect.kind), 32'(MP_JALR), "empty RAS return kind");
  endtask

  task automatic counter_learning();
    addr_t pc;
    addr_t tgt;
    pc  = rand_pc();
    tgt = rand_pc();
    // Weakly not-taken counter, so only the first taken pass is wrong
    send_and_check(make_rec(1'b1, 1'b0, 1'b0, pc, 1'b1, tgt));
    check_eq(32'(redirect.valid), 32'd1, "first taken pass redirect");
    send_and_check(make_rec(1'b1, 1'b0, 1'b0, pc, 1'b1, tgt));
    check_eq(32'(redirect.valid), 32'd0, "second taken pass redirect");
    repeat (4) begin
      send_and_check(make_rec(1'b1, 1'b0, 1'b0, pc, 1'b0, tgt));
      if (redirect.valid) begin
        check_eq(redirect.pc, pc + 32'd4, "not-taken redirect pc");
      end
    end
  endtask

  task automatic return_prediction();
    addr_t pc;
    pc = rand_pc();
    send_and_check(make_rec(1'b0, 1'b1, 1'b0, pc, 1'b1, rand_pc()));
    send_and_check(make_rec(1'b0, 1'b0, 1'b1, rand_pc(), 1'b1, pc + 32'd4));
    check_eq(32'(redirect.valid), 32'd0, "matching return redirect");
    pc = rand_pc();
    send_and_check(make_rec(1'b0, 1'b1, 1'b0, pc, 1'b1, rand_pc()));
    // Return lands one word past the link address
    send_and_check(make_rec(1'b0, 1'b0, 1'b1, rand_pc(), 1'b1, pc + 32'd8));
    check_eq(32'(redirect.kind), 32'(MP_JALR), "wrong return kind");
    check_eq(redirect.pc, pc + 32'd8, "wrong return redirect pc");
  endtask

  task automatic flush_after_mispredict();
    inst_rec_t a;
    inst_rec_t b;
    inst_rec_t c;
    redirect_t exp_a;
    redirect_t exp_c;
    addr_t     pc;
    pc = rand_pc();
    // Outcome opposite to the model counter, so A always mispredicts
    a  = make_rec(1'b1, 1'b0, 1'b0, pc, !bht_m[pc[2 +: `BPRED_BHT_IDX_BITS]][1], rand_pc());
    // B is a call, a leak would show up as a RAS push later
    b  = make_rec(1'b0, 1'b1, 1'b0, rand_pc(), 1'b1, rand_pc());
    c  = make_rec(1'b1, 1'b0, 1'b0, rand_pc(), lfsr_bit(), rand_pc());
    exp_a = model_redirect(a);
    model_update(a);
    exp_c = model_redirect(c);
    @(posedge clk);
    in_valid <= 1'b1;
    in_rec   <= a;
    @(posedge clk);
    in_rec <= b;
    @(posedge clk);
    in_rec <= c;
    @(negedge clk);
    check_outputs(exp_a, a.pc);
    check_eq(32'(redirect.valid), 32'd1, "flush source redirect");
    @(posedge clk);
    in_valid <= 1'b0;
    @(negedge clk);
    check_eq(32'(retire_valid), 32'd0, "flushed instruction retire_valid");
    check_eq(32'(redirect.valid), 32'd0, "flushed instruction redirect");
    @(negedge clk);
    check_outputs(exp_c, c.pc);
    model_update(c);
  endtask

  task automatic random_sequence();
    logic [31:0] sel;
    addr_t       pc;
    addr_t       tgt;
    inst_rec_t   r;
    for (int i = 0; i < 40; i++) begin
      sel = rand_bits(2);
      pc  = rand_pc();
      tgt = rand_pc();
      if (!sel[1]) begin
        r = make_rec(1'b1, 1'b0, 1'b0, pc, lfsr_bit(), tgt);
      end else if (!sel[0]) begin
        r = make_rec(1'b0, 1'b1, 1'b0, pc, 1'b1, tgt);
      end else begin
        // About half the returns go where the stack points
        if (lfsr_bit() && ras_m.size() != 0) begin
          tgt = ras_m[0];
        end
        r = make_rec(1'b0, 1'b0, 1'b1, pc, 1'b1, tgt);
      end
      send_and_check(r);
    end
  endtask

  initial begin
    #(watchdog_cycles * clk_period);
    $display("Watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
    $display(">>> FAIL");
    $fatal(1, "timeout");
  end

  initial begin
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_rec     = '0;
    lfsr_state = 32'h7a6a54c8;
    for (int i = 0; i < (1 << `BPRED_BHT_IDX_BITS); i++) begin
      bht_m[i] = 2'b01;
    end
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    reset_state_idle();
    empty_ras_return();
    counter_learning();
    return_prediction();
    flush_after_mispredict();
    random_sequence();
    @(negedge clk);
    if (UUT.u_checker.fail_count == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("Checker saw %0d assertion failures", UUT.u_checker.fail_count);
      $display(">>> FAIL");
      $fatal(1, "assertion failures");
    end
  end

endmodule

// ==== tb.f ====
+incdir+src
src/bpred_pkg.sv
src/bpred_lookup.sv
src/bpred_ex_mem_reg.sv
src/bpred_mem_check.sv
src/bpred_top.sv
testbench/bpred_checker.sv
testbench/bpred_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module bpred_tb -o bpred_sim \
  && ./obj_dir/bpred_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx '>>> PASS' sim.log && echo "bpred simulation passed" \
  || { echo "bpred simulation failed"; exit 1; }
